// ==== sim.f ====
design/decodePkg.sv
design/instDecoder.sv
design/stageReg.sv
design/operandSelect.sv
design/decodeStage.sv
test/decodeStage_assertions.sv
test/decodeStageTb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --assert -j 0
TOP      = decodeStageTb
FILELIST = sim.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG)
	cat $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== test/decodeStageTb.sv ====
module decodeStageTb;

    typedef enum {srcZero, srcEx, srcMem, srcReg} srcT;

    typedef struct {
        logic [31:0]         inst;
        logic [31:0]         pc;
        logic                exRdE;
        logic [4:0]          exRdIdx;
        logic [31:0]         exRdData;
        decodePkg::instIdxT  exInstIdx;
        logic                memRdE;
        logic [4:0]          memRdIdx;
        logic [31:0]         memRdData;
        logic                stall;
        decodePkg::instIdxT  instIdx;
        decodePkg::instTypeT instType;
        logic                rdE;
        logic [4:0]          rdIdx;
        logic [31:0]         imm;
        srcT                 src1;
        srcT                 src2;
    } vecT;

    localparam int streamLen = 20;

    logic                clk = 1'b0;
    logic                rstN;
    logic                inStrobe;
    logic [31:0]         inst;
    logic [31:0]         pc;
    logic                reg1E;
    logic [4:0]          reg1Idx;
    logic                reg2E;
    logic [4:0]          reg2Idx;
    logic [31:0]         reg1Data;
    logic [31:0]         reg2Data;
    logic                exRdE;
    logic [4:0]          exRdIdx;
    logic [31:0]         exRdData;
    decodePkg::instIdxT  exInstIdx;
    logic                memRdE;
    logic [4:0]          memRdIdx;
    logic [31:0]         memRdData;
    logic                outStrobe;
    logic [31:0]         issuePc;
    decodePkg::instIdxT  instIdx;
    decodePkg::instTypeT instType;
    logic                rdE;
    logic [4:0]          rdIdx;
    logic [31:0]         rs1Data;
    logic [31:0]         rs2Data;
    logic [31:0]         imm;
    logic                idStall;

    vecT vecs[$];
    vecT fwd;                                                   // Forwarding for new entries
    int  numDirected;
    int  valueErrs = 0;
    int  strobeErrs = 0;
    int  cycleCount = 0;
    int  cycleLimit;

    decodeStage dut_i (.*);

    always #50 clk = ~clk;

    // Register file model where index i holds i * 0x01010101
    assign reg1Data = 32'(reg1Idx) * 32'h01010101;
    assign reg2Data = 32'(reg2Idx) * 32'h01010101;

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout: the run was stopped after %0d cycles", cycleCount);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    task automatic setForwarding(input logic exE, input logic [4:0] exIdx,
                                 input logic [31:0] exData, input decodePkg::instIdxT exId,
                                 input logic memE, input logic [4:0] memIdx,
                                 input logic [31:0] memData);
        fwd.exRdE     = exE;
        fwd.exRdIdx   = exIdx;
        fwd.exRdData  = exData;
        fwd.exInstIdx = exId;
        fwd.memRdE    = memE;
        fwd.memRdIdx  = memIdx;
        fwd.memRdData = memData;
    endtask

    task automatic addVec(input logic [31:0] word, input logic expStall,
                          input decodePkg::instIdxT id, input decodePkg::instTypeT kind,
                          input logic expRdE, input logic [4:0] rd, input logic [31:0] expImm,
                          input srcT src1, input srcT src2);
        vecT v;
        v          = fwd;
        v.inst     = word;
        v.pc       = 32'h1000 + 32'(vecs.size()) * 32'd4;
        v.stall    = expStall;
        v.instIdx  = id;
        v.instType = kind;
        v.rdE      = expRdE;
        v.rdIdx    = rd;
        v.imm      = expImm;
        v.src1     = src1;
        v.src2     = src2;
        vecs.push_back(v);
    endtask

    // Fixed registers per group are rd 3, rs1 1 and rs2 2
    task automatic aluRegVec(input logic f7b5, input logic [2:0] f3,
                             input decodePkg::instIdxT id);
        addVec({1'b0, f7b5, 5'd0, 5'd2, 5'd1, f3, 5'd3, 7'b0110011}, 1'b0, id,
               decodePkg::typeAlu, 1'b1, 5'd3, 32'd0, srcReg, srcReg);
    endtask

    task automatic aluImmVec(input logic [11:0] imm12, input logic [2:0] f3,
                             input decodePkg::instIdxT id, input logic [31:0] expImm);
        addVec({imm12, 5'd4, f3, 5'd5, 7'b0010011}, 1'b0, id,
               decodePkg::typeAlu, 1'b1, 5'd5, expImm, srcReg, srcZero);
    endtask

    task automatic loadVec(input logic [11:0] imm12, input logic [2:0] f3,
                           input decodePkg::instIdxT id, input logic [31:0] expImm);
        addVec({imm12, 5'd6, f3, 5'd7, 7'b0000011}, 1'b0, id,
               decodePkg::typeLoad, 1'b1, 5'd7, expImm, srcReg, srcZero);
    endtask

    task automatic storeVec(input logic [11:0] imm12, input logic [2:0] f3,
                            input decodePkg::instIdxT id, input logic [31:0] expImm);
        addVec({imm12[11:5], 5'd8, 5'd9, f3, imm12[4:0], 7'b0100011}, 1'b0, id,
               decodePkg::typeStore, 1'b0, 5'd0, expImm, srcReg, srcReg);
    endtask

    task automatic upperVec(input logic [19:0] imm20, input logic [6:0] op,
                            input decodePkg::instIdxT id, input logic [31:0] expImm);
        addVec({imm20, 5'd10, op}, 1'b0, id, decodePkg::typeAlu, 1'b1, 5'd10, expImm,
               srcZero, srcZero);
    endtask

    task automatic nopVec(input logic [31:0] word);
        addVec(word, 1'b0, decodePkg::idNop, decodePkg::typeNop, 1'b0, 5'd0, 32'd0,
               srcZero, srcZero);
    endtask

    function automatic logic [31:0] expData(input srcT s, input logic [4:0] idx, input vecT v);
        case (s)
            srcEx:   return v.exRdData;
            srcMem:  return v.memRdData;
            srcReg:  return 32'(idx) * 32'h01010101;
            default: return 32'd0;
        endcase
    endfunction

    task automatic compare(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERR %0t %s: got %h, expected %h", $time, name, actual, expected);
            valueErrs++;
        end
    endtask

    task automatic driveVec(input vecT v);
        inStrobe  <= 1'b1;
        inst      <= v.inst;
        pc        <= v.pc;
        exRdE     <= v.exRdE;
        exRdIdx   <= v.exRdIdx;
        exRdData  <= v.exRdData;
        exInstIdx <= v.exInstIdx;
        memRdE    <= v.memRdE;
        memRdIdx  <= v.memRdIdx;
        memRdData <= v.memRdData;
    endtask

    task automatic checkOutputs(input vecT v);
        if (outStrobe !== !v.stall) begin
            $display("At time %0t outStrobe was %b for the instruction at pc %h, expected %b",
                     $time, outStrobe, v.pc, !v.stall);
            strobeErrs++;
        end else if (outStrobe) begin
            compare("pc", issuePc, v.pc);
            compare("instIdx", 32'(instIdx), 32'(v.instIdx));
            compare("instType", 32'(instType), 32'(v.instType));
            compare("rdE", 32'(rdE), 32'(v.rdE));
            compare("rdIdx", 32'(rdIdx), 32'(v.rdIdx));
            compare("imm", imm, v.imm);
            compare("rs1Data", rs1Data, expData(v.src1, v.inst[19:15], v));
            compare("rs2Data", rs2Data, expData(v.src2, v.inst[24:20], v));
        end
    endtask

    initial begin
        logic [31:0] addInst;
        logic [31:0] addX0;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm12;

        void'($urandom(32'hd40deba7));
        rstN      = 1'b0;
        inStrobe  = 1'b0;
        inst      = 32'd0;
        pc        = 32'd0;
        exRdE     = 1'b0;
        exRdIdx   = 5'd0;
        exRdData  = 32'd0;
        exInstIdx = decodePkg::idNop;
        memRdE    = 1'b0;
        memRdIdx  = 5'd0;
        memRdData = 32'd0;
        setForwarding(1'b0, 5'd0, 32'd0, decodePkg::idNop, 1'b0, 5'd0, 32'd0);

        upperVec(20'habcde, 7'b0110111, decodePkg::idLui, 32'habcd_e000);
        upperVec(20'h80000, 7'b0010111, decodePkg::idAuipc, 32'h8000_0000);
        loadVec(12'h800, 3'b000, decodePkg::idLb, 32'hffff_f800);
        loadVec(12'h7fe, 3'b001, decodePkg::idLh, 32'h0000_07fe);
        loadVec(12'hffc, 3'b010, decodePkg::idLw, 32'hffff_fffc);
        loadVec(12'h001, 3'b100, decodePkg::idLbu, 32'h0000_0001);
        loadVec(12'h010, 3'b101, decodePkg::idLhu, 32'h0000_0010);
        storeVec(12'hfff, 3'b000, decodePkg::idSb, 32'hffff_ffff);
        storeVec(12'h7e0, 3'b001, decodePkg::idSh, 32'h0000_07e0);
        storeVec(12'h804, 3'b010, decodePkg::idSw, 32'hffff_f804);
        aluImmVec(12'hfff, 3'b000, decodePkg::idAddi, 32'hffff_ffff);
        aluImmVec(12'h7ff, 3'b010, decodePkg::idSlti, 32'h0000_07ff);
        aluImmVec(12'h800, 3'b011, decodePkg::idSltiu, 32'hffff_f800);
        aluImmVec(12'h123, 3'b100, decodePkg::idXori, 32'h0000_0123);
        aluImmVec(12'hf00, 3'b110, decodePkg::idOri, 32'hffff_ff00);
        aluImmVec(12'h0ff, 3'b111, decodePkg::idAndi, 32'h0000_00ff);
        aluImmVec(12'h01f, 3'b001, decodePkg::idSlli, 32'd31);
        aluImmVec(12'h005, 3'b101, decodePkg::idSrli, 32'd5);
        aluImmVec(12'h41c, 3'b101, decodePkg::idSrai, 32'd28);      // Shamt only
        aluRegVec(1'b0, 3'b000, decodePkg::idAdd);
        aluRegVec(1'b1, 3'b000, decodePkg::idSub);
        aluRegVec(1'b0, 3'b001, decodePkg::idSll);
        aluRegVec(1'b0, 3'b010, decodePkg::idSlt);
        aluRegVec(1'b0, 3'b011, decodePkg::idSltu);
        aluRegVec(1'b0, 3'b100, decodePkg::idXor);
        aluRegVec(1'b0, 3'b101, decodePkg::idSrl);
        aluRegVec(1'b1, 3'b101, decodePkg::idSra);
        aluRegVec(1'b0, 3'b110, decodePkg::idOr);
        aluRegVec(1'b0, 3'b111, decodePkg::idAnd);
        nopVec({7'h00, 5'd2, 5'd1, 3'b000, 5'h08, 7'b1100011});     // BEQ
        nopVec({20'h00100, 5'd1, 7'b1101111});                      // JAL
        nopVec({12'h004, 5'd1, 3'b000, 5'd1, 7'b1100111});          // JALR
        nopVec({12'h000, 5'd1, 3'b011, 5'd3, 7'b0000011});          // Load with funct3 011
        nopVec({7'h00, 5'd2, 5'd1, 3'b011, 5'd0, 7'b0100011});      // Store with funct3 011
        nopVec({12'h401, 5'd1, 3'b001, 5'd3, 7'b0010011});          // SLLI with funct7 bit 5
        nopVec({7'h20, 5'd2, 5'd1, 3'b010, 5'd3, 7'b0110011});      // SLT with funct7 bit 5
        nopVec(32'hffff_ffff);

        addInst = {7'h00, 5'd6, 5'd5, 3'b000, 5'd3, 7'b0110011};   // ADD x3, x5, x6
        addX0   = {7'h00, 5'd6, 5'd0, 3'b000, 5'd3, 7'b0110011};   // ADD x3, x0, x6
        setForwarding(1'b1, 5'd5, 32'he0e0_0005, decodePkg::idAdd, 1'b1, 5'd5, 32'ha0a0_0005);
        addVec(addInst, 1'b0, decodePkg::idAdd, decodePkg::typeAlu, 1'b1, 5'd3, 32'd0,
               srcEx, srcReg);
        setForwarding(1'b1, 5'd7, 32'h1111_1111, decodePkg::idAdd, 1'b1, 5'd6, 32'ha0a0_0006);
        addVec(addInst, 1'b0, decodePkg::idAdd, decodePkg::typeAlu, 1'b1, 5'd3, 32'd0,
               srcReg, srcMem);
        setForwarding(1'b1, 5'd0, 32'hdead_0000, decodePkg::idLw, 1'b1, 5'd0, 32'hbeef_0000);
        addVec(addX0, 1'b0, decodePkg::idAdd, decodePkg::typeAlu, 1'b1, 5'd3, 32'd0,
               srcReg, srcReg);
        setForwarding(1'b1, 5'd6, 32'h5555_5555, decodePkg::idLw, 1'b0, 5'd0, 32'd0);
        addVec(addInst, 1'b1, decodePkg::idAdd, decodePkg::typeAlu, 1'b1, 5'd3, 32'd0,
               srcReg, srcReg);
        setForwarding(1'b0, 5'd5, 32'd0, decodePkg::idSw, 1'b0, 5'd0, 32'd0);
        addVec(addInst, 1'b0, decodePkg::idAdd, decodePkg::typeAlu, 1'b1, 5'd3, 32'd0,
               srcReg, srcReg);
        setForwarding(1'b1, 5'd7, 32'h7777_7777, decodePkg::idLw, 1'b0, 5'd0, 32'd0);
        addVec(addInst, 1'b0, decodePkg::idAdd, decodePkg::typeAlu, 1'b1, 5'd3, 32'd0,
               srcReg, srcReg);
        numDirected = vecs.size();

        // Stream of ADDI and ADD with random registers and immediates
        setForwarding(1'b0, 5'd0, 32'd0, decodePkg::idNop, 1'b0, 5'd0, 32'd0);
        for (int k = 0; k < streamLen; k++) begin
            rd    = 5'($urandom());
            rs1   = 5'($urandom());
            rs2   = 5'($urandom());
            imm12 = 12'($urandom());
            if (k % 2 == 0) begin
                addVec({imm12, rs1, 3'b000, rd, 7'b0010011}, 1'b0, decodePkg::idAddi,
                       decodePkg::typeAlu, 1'b1, rd, {{20{imm12[11]}}, imm12}, srcReg, srcZero);
            end else begin
                addVec({7'h00, rs2, rs1, 3'b000, rd, 7'b0110011}, 1'b0, decodePkg::idAdd,
                       decodePkg::typeAlu, 1'b1, rd, 32'd0, srcReg, srcReg);
            end
        end
        cycleLimit = 16 + 4 * vecs.size() + 40;

        repeat (16) @(posedge clk);
        rstN <= 1'b1;

        for (int i = 0; i < numDirected; i++) begin
            @(posedge clk);
            driveVec(vecs[i]);
            @(posedge clk);
            inStrobe <= 1'b0;
            @(negedge clk);
            compare("idStall", 32'(idStall), 32'(vecs[i].stall));
            compare("reg1E", 32'(reg1E), 32'(vecs[i].src1 != srcZero));
            compare("reg2E", 32'(reg2E), 32'(vecs[i].src2 != srcZero));
            @(posedge clk);
            @(negedge clk);
            checkOutputs(vecs[i]);
        end

        for (int k = 0; k < streamLen + 2; k++) begin
            @(posedge clk);
            if (k < streamLen) begin
                driveVec(vecs[numDirected + k]);
            end else begin
                inStrobe <= 1'b0;
            end
            @(negedge clk);
            if (k >= 2) begin
                checkOutputs(vecs[numDirected + k - 2]);            // Two cycles behind
            end
        end

        @(posedge clk);
        $display("Value errors: %0d, strobe errors: %0d", valueErrs, strobeErrs);
        if (valueErrs == 0 && strobeErrs == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== test/decodeStage_assertions.sv ====
module decodeStageAssertions (
    input logic               clk,
    input logic               rstN,
    input logic               inStrobe,
    input logic               outStrobe,
    input logic               idStall,
    input decodePkg::instIdxT exInstIdx
);

    // Low in reset and on the first cycle out of it
    assert property (@(posedge clk) (!$past(rstN) || !$past(rstN, 2)) |-> !outStrobe)
        else $error("outStrobe high during or right after reset");

    // Only a load in EX can stall
    assert property (@(posedge clk) disable iff (!rstN)
        idStall |-> exInstIdx inside {decodePkg::idLb, decodePkg::idLh, decodePkg::idLw,
                                      decodePkg::idLbu, decodePkg::idLhu})
        else $error("idStall high without a load in EX");

    assert property (@(posedge clk) disable iff (!rstN)
        $past(inStrobe, 2) |-> outStrobe == !$past(idStall))
        else $error("outStrobe does not follow the strobe two cycles later");

endmodule

bind decodeStage decodeStageAssertions checks (
    .clk       (clk),
    .rstN      (rstN),
    .inStrobe  (inStrobe),
    .outStrobe (outStrobe),
    .idStall   (idStall),
    .exInstIdx (exInstIdx)
);

// ==== design/decodeStage.sv ====
module decodeStage (
    input  logic                            clk,
    input  logic                            rstN,

    input  logic                            inStrobe,
    input  logic [decodePkg::InstW-1:0]     inst,
    input  logic [decodePkg::XLen-1:0]      pc,

    output logic                            reg1E,
    output logic [decodePkg::RegIdxW-1:0]   reg1Idx,
    output logic                            reg2E,
    output logic [decodePkg::RegIdxW-1:0]   reg2Idx,
    input  logic [decodePkg::XLen-1:0]      reg1Data,
    input  logic [decodePkg::XLen-1:0]      reg2Data,

    input  logic                            exRdE,
    input  logic [decodePkg::RegIdxW-1:0]   exRdIdx,
    input  logic [decodePkg::XLen-1:0]      exRdData,
    input  decodePkg::instIdxT              exInstIdx,

    input  logic                            memRdE,          // Non-memory MEM results only
    input  logic [decodePkg::RegIdxW-1:0]   memRdIdx,
    input  logic [decodePkg::XLen-1:0]      memRdData,

    output logic                            outStrobe,
    output logic [decodePkg::XLen-1:0]      issuePc,         // pc of the issued instruction
    output decodePkg::instIdxT              instIdx,
    output decodePkg::instTypeT             instType,
    output logic                            rdE,
    output logic [decodePkg::RegIdxW-1:0]   rdIdx,
    output logic [decodePkg::XLen-1:0]      rs1Data,
    output logic [decodePkg::XLen-1:0]      rs2Data,
    output logic [decodePkg::XLen-1:0]      imm,
    output logic                            idStall
);

    decodePkg::decodedT decodedNow;
    decodePkg::decodedT decodedBuf;
    logic               decodeValid;
    decodePkg::issueT   issueNext;
    logic               issueNextStrobe;
    decodePkg::issueT   issueOut;

    instDecoder decoder (
        .inst    (inst),
        .pc      (pc),
        .decoded (decodedNow)
    );

    stageReg #(.payloadT(decodePkg::decodedT)) decodeBuf (
        .clk       (clk),
        .rstN      (rstN),
        .inStrobe  (inStrobe),
        .inData    (decodedNow),
        .outStrobe (decodeValid),
        .outData   (decodedBuf)
    );

    // Register file reads only for a live instruction
    assign reg1E   = decodeValid && decodedBuf.reg1E;
    assign reg1Idx = decodedBuf.reg1Idx;
    assign reg2E   = decodeValid && decodedBuf.reg2E;
    assign reg2Idx = decodedBuf.reg2Idx;

    operandSelect opSel (
        .decoded     (decodedBuf),
        .valid       (decodeValid),
        .reg1Data    (reg1Data),
        .reg2Data    (reg2Data),
        .exRdE       (exRdE),
        .exRdIdx     (exRdIdx),
        .exRdData    (exRdData),
        .exInstIdx   (exInstIdx),
        .memRdE      (memRdE),
        .memRdIdx    (memRdIdx),
        .memRdData   (memRdData),
        .issue       (issueNext),
        .issueStrobe (issueNextStrobe),
        .stall       (idStall)
    );

    stageReg #(.payloadT(decodePkg::issueT)) issueBuf (
        .clk       (clk),
        .rstN      (rstN),
        .inStrobe  (issueNextStrobe),
        .inData    (issueNext),
        .outStrobe (outStrobe),
        .outData   (issueOut)
    );

    assign issuePc  = issueOut.pc;
    assign instIdx  = issueOut.instIdx;
    assign instType = issueOut.instType;
    assign rdE      = issueOut.rdE;
    assign rdIdx    = issueOut.rdIdx;
    assign rs1Data  = issueOut.rs1Data;
    assign rs2Data  = issueOut.rs2Data;
    assign imm      = issueOut.imm;

endmodule

// ==== design/operandSelect.sv ====
module operandSelect (
    input  decodePkg::decodedT              decoded,
    input  logic                            valid,
    input  logic [decodePkg::XLen-1:0]      reg1Data,
    input  logic [decodePkg::XLen-1:0]      reg2Data,
    input  logic                            exRdE,
    input  logic [decodePkg::RegIdxW-1:0]   exRdIdx,
    input  logic [decodePkg::XLen-1:0]      exRdData,
    input  decodePkg::instIdxT              exInstIdx,
    input  logic                            memRdE,
    input  logic [decodePkg::RegIdxW-1:0]   memRdIdx,
    input  logic [decodePkg::XLen-1:0]      memRdData,
    output decodePkg::issueT                issue,
    output logic                            issueStrobe,
    output logic                            stall
);

    logic exIsLoad;
    logic exLoadDst;
    logic reg1Stall;
    logic reg2Stall;

    // Disabled read, then EX, then MEM, then register file; x0 never forwarded
    function automatic logic [decodePkg::XLen-1:0] resolve(
        input logic                          readE,
        input logic [decodePkg::RegIdxW-1:0] idx,
        input logic [decodePkg::XLen-1:0]    rfData
    );
        if (!readE) begin
            return '0;
        end
        if (exRdE && idx != '0 && exRdIdx == idx) begin
            return exRdData;
        end
        if (memRdE && idx != '0 && memRdIdx == idx) begin
            return memRdData;
        end
        return rfData;
    endfunction

    // Stores write no register, so only loads can cause a load-use hazard
    assign exIsLoad = exInstIdx inside {decodePkg::idLb, decodePkg::idLh, decodePkg::idLw,
                                        decodePkg::idLbu, decodePkg::idLhu};
    assign exLoadDst = exIsLoad && exRdIdx != '0;

    assign reg1Stall = decoded.reg1E && exLoadDst && decoded.reg1Idx == exRdIdx;
    assign reg2Stall = decoded.reg2E && exLoadDst && decoded.reg2Idx == exRdIdx;

    assign stall       = valid && (reg1Stall || reg2Stall);
    assign issueStrobe = valid && !stall;                       // Stalled instruction dropped

    always_comb begin
        issue.pc       = decoded.pc;
        issue.instIdx  = decoded.instIdx;
        issue.instType = decoded.instType;
        issue.rdE      = decoded.rdE;
        issue.rdIdx    = decoded.rdIdx;
        issue.rs1Data  = resolve(decoded.reg1E, decoded.reg1Idx, reg1Data);
        issue.rs2Data  = resolve(decoded.reg2E, decoded.reg2Idx, reg2Data);
        issue.imm      = decoded.imm;
    end

endmodule

// ==== design/stageReg.sv ====
module stageReg #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    rstN,
    input  logic    inStrobe,
    input  payloadT inData,
    output logic    outStrobe,
    output payloadT outData
);

    // Valid flag tracks the strobe every cycle
    always_ff @(posedge clk) begin
        if (!rstN) begin
            outStrobe <= 1'b0;
        end else begin
            outStrobe <= inStrobe;
        end
    end

    always_ff @(posedge clk) begin
        if (inStrobe) begin
            outData <= inData;                                  // Held until next strobe
        end
    end

endmodule

// ==== design/instDecoder.sv ====
module instDecoder (
    input  logic [decodePkg::InstW-1:0] inst,
    input  logic [decodePkg::XLen-1:0]  pc,
    output decodePkg::decodedT          decoded
);

    decodePkg::opcodeT              opcode;
    logic [2:0]                     funct3;
    logic                           funct7b5;
    logic [decodePkg::RegIdxW-1:0]  rdIdx;
    logic [decodePkg::RegIdxW-1:0]  rs1Idx;
    logic [decodePkg::RegIdxW-1:0]  rs2Idx;
    logic [decodePkg::XLen-1:0]     immI;
    logic [decodePkg::XLen-1:0]     immS;
    logic [decodePkg::XLen-1:0]     immU;
    logic [decodePkg::XLen-1:0]     immShamt;
    decodePkg::instIdxT             instIdx;

    assign opcode   = decodePkg::opcodeT'(inst[6:0]);
    assign funct3   = inst[14:12];
    assign funct7b5 = inst[30];
    assign rdIdx    = inst[11:7];
    assign rs1Idx   = inst[19:15];
    assign rs2Idx   = inst[24:20];

    assign immI     = {{(decodePkg::XLen-12){inst[31]}}, inst[31:20]};
    assign immS     = {{(decodePkg::XLen-12){inst[31]}}, inst[31:25], inst[11:7]};
    assign immU     = {inst[31:12], 12'b0};
    assign immShamt = {{(decodePkg::XLen-5){1'b0}}, inst[24:20]};   // Zero-extended

    // Instruction ID; anything undefined stays idNop
    always_comb begin
        instIdx = decodePkg::idNop;
        case (opcode)
            decodePkg::opLui:   instIdx = decodePkg::idLui;
            decodePkg::opAuipc: instIdx = decodePkg::idAuipc;
            decodePkg::opLoad: begin
                case (funct3)
                    3'b000:  instIdx = decodePkg::idLb;
                    3'b001:  instIdx = decodePkg::idLh;
                    3'b010:  instIdx = decodePkg::idLw;
                    3'b100:  instIdx = decodePkg::idLbu;
                    3'b101:  instIdx = decodePkg::idLhu;
                    default: instIdx = decodePkg::idNop;
                endcase
            end
            decodePkg::opStore: begin
                case (funct3)
                    3'b000:  instIdx = decodePkg::idSb;
                    3'b001:  instIdx = decodePkg::idSh;
                    3'b010:  instIdx = decodePkg::idSw;
                    default: instIdx = decodePkg::idNop;
                endcase
            end
            decodePkg::opRegImm: begin
                case (funct3)
                    3'b000:  instIdx = decodePkg::idAddi;
                    3'b010:  instIdx = decodePkg::idSlti;
                    3'b011:  instIdx = decodePkg::idSltiu;
                    3'b100:  instIdx = decodePkg::idXori;
                    3'b110:  instIdx = decodePkg::idOri;
                    3'b111:  instIdx = decodePkg::idAndi;
                    3'b001:  instIdx = funct7b5 ? decodePkg::idNop : decodePkg::idSlli;
                    default: instIdx = funct7b5 ? decodePkg::idSrai : decodePkg::idSrli;
                endcase
            end
            decodePkg::opRegReg: begin
                // funct7 bit 5 only selects SUB and SRA
                case (funct3)
                    3'b000:  instIdx = funct7b5 ? decodePkg::idSub : decodePkg::idAdd;
                    3'b001:  instIdx = funct7b5 ? decodePkg::idNop : decodePkg::idSll;
                    3'b010:  instIdx = funct7b5 ? decodePkg::idNop : decodePkg::idSlt;
                    3'b011:  instIdx = funct7b5 ? decodePkg::idNop : decodePkg::idSltu;
                    3'b100:  instIdx = funct7b5 ? decodePkg::idNop : decodePkg::idXor;
                    3'b110:  instIdx = funct7b5 ? decodePkg::idNop : decodePkg::idOr;
                    3'b111:  instIdx = funct7b5 ? decodePkg::idNop : decodePkg::idAnd;
                    default: instIdx = funct7b5 ? decodePkg::idSra : decodePkg::idSrl;
                endcase
            end
            default: instIdx = decodePkg::idNop;                // Branches, jumps, unknown
        endcase
    end

    always_comb begin
        decoded    = '0;
        decoded.pc = pc;
        if (instIdx != decodePkg::idNop) begin
            decoded.instIdx = instIdx;
            case (opcode)
                decodePkg::opLui, decodePkg::opAuipc: begin
                    decoded.instType = decodePkg::typeAlu;
                    decoded.rdE      = 1'b1;
                    decoded.rdIdx    = rdIdx;
                    decoded.imm      = immU;
                end
                decodePkg::opLoad: begin
                    decoded.instType = decodePkg::typeLoad;
                    decoded.rdE      = 1'b1;
                    decoded.rdIdx    = rdIdx;
                    decoded.reg1E    = 1'b1;
                    decoded.reg1Idx  = rs1Idx;
                    decoded.imm      = immI;
                end
                decodePkg::opStore: begin
                    decoded.instType = decodePkg::typeStore;
                    decoded.reg1E    = 1'b1;
                    decoded.reg1Idx  = rs1Idx;
                    decoded.reg2E    = 1'b1;
                    decoded.reg2Idx  = rs2Idx;
                    decoded.imm      = immS;
                end
                decodePkg::opRegImm: begin
                    decoded.instType = decodePkg::typeAlu;
                    decoded.rdE      = 1'b1;
                    decoded.rdIdx    = rdIdx;
                    decoded.reg1E    = 1'b1;
                    decoded.reg1Idx  = rs1Idx;
                    decoded.imm      = (funct3 == 3'b001 || funct3 == 3'b101) ? immShamt : immI;
                end
                decodePkg::opRegReg: begin
                    decoded.instType = decodePkg::typeAlu;
                    decoded.rdE      = 1'b1;
                    decoded.rdIdx    = rdIdx;
                    decoded.reg1E    = 1'b1;
                    decoded.reg1Idx  = rs1Idx;
                    decoded.reg2E    = 1'b1;
                    decoded.reg2Idx  = rs2Idx;
                end
                default: decoded.instIdx = decodePkg::idNop;
            endcase
        end
    end

endmodule

// ==== design/decodePkg.sv ====
package decodePkg;

    parameter int XLen    = 32;
    parameter int RegIdxW = 5;
    parameter int InstW   = 32;

    // Major opcodes of the kept RV32I groups
    typedef enum logic [6:0] {
        opLui    = 7'b0110111,
        opAuipc  = 7'b0010111,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opRegImm = 7'b0010011,
        opRegReg = 7'b0110011
    } opcodeT;

    typedef enum logic [5:0] {
        idNop = 6'd0,
        idLui, idAuipc,
        idLb, idLh, idLw, idLbu, idLhu,                         // Loads
        idSb, idSh, idSw,                                       // Stores
        idAddi, idSlti, idSltiu, idXori, idOri, idAndi,
        idSlli, idSrli, idSrai,
        idAdd, idSub, idSll, idSlt, idSltu,
        idXor, idSrl, idSra, idOr, idAnd
    } instIdxT;

    typedef enum logic [1:0] {
        typeNop,
        typeAlu,
        typeLoad,
        typeStore
    } instTypeT;

    typedef struct packed {
        logic [XLen-1:0]    pc;
        instIdxT            instIdx;
        instTypeT           instType;
        logic               rdE;
        logic [RegIdxW-1:0] rdIdx;
        logic               reg1E;
        logic [RegIdxW-1:0] reg1Idx;
        logic               reg2E;
        logic [RegIdxW-1:0] reg2Idx;
        logic [XLen-1:0]    imm;
    } decodedT;

    // Resolved packet handed to EX
    typedef struct packed {
        logic [XLen-1:0]    pc;
        instIdxT            instIdx;
        instTypeT           instType;
        logic               rdE;
        logic [RegIdxW-1:0] rdIdx;
        logic [XLen-1:0]    rs1Data;
        logic [XLen-1:0]    rs2Data;
        logic [XLen-1:0]    imm;
    } issueT;

endpackage
